//--- Bender.yml
package:
  name: dzCpu

sources:
  - verilog/cpuPkg.sv
  - verilog/z80Pkg.sv
  - verilog/microcodeRom.sv
  - verilog/microSequencer.sv
  - verilog/registerFile.sv
  - verilog/interruptCtrl.sv
  - verilog/uopExecute.sv
  - verilog/dzCpu.sv
  - target: test
    files:
      - verif/dzCpu_assert.sv
      - verif/dzCpuTb.sv

//--- compile.f
verilog/cpuPkg.sv
verilog/z80Pkg.sv
verilog/microcodeRom.sv
verilog/microSequencer.sv
verilog/registerFile.sv
verilog/interruptCtrl.sv
verilog/uopExecute.sv
verilog/dzCpu.sv
verif/dzCpu_assert.sv
verif/dzCpuTb.sv

//--- verif/dzCpuTb.sv
`timescale 1ns/1ps

module dzCpuTb;

  logic        iClock;
  logic        rstN;
  logic [3:0]  interruptRequests;
  logic [7:0]  mcuReadData;
  logic [15:0] mcuAddr;
  logic [7:0]  mcuWriteData;
  logic        mcuWe;
  logic        mcuReadRequest;

  logic [7:0]  mem [0:65535];
  logic [15:0] logAddr[$];
  logic [7:0]  logData[$];
  logic [15:0] expAddr[$];
  logic [7:0]  expData[$];
  logic [15:0] loadAddr;
  int          instrCount;
  int          testErrors;
  int          errorCount;
  int          testCount;
  int          failedTests;
  integer      seed = 16819;
  logic [2:0]  regCodes [7] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd7};  // Opcode order
  logic [7:0]  aluOps [3] = '{8'hA0, 8'hA8, 8'hB0};  // AND, XOR, OR

  dzCpu #(.ResetPc(16'h0100)) dut0 (
    .iClock            (iClock),
    .rstN              (rstN),
    .mcuReadData       (mcuReadData),
    .interruptRequests (interruptRequests),
    .mcuAddr           (mcuAddr),
    .mcuWriteData      (mcuWriteData),
    .mcuWe             (mcuWe),
    .mcuReadRequest    (mcuReadRequest)
  );

  initial
  begin
    iClock = 1'b0;
    forever #4 iClock = ~iClock;
  end

  // --------------------------------------------------
  // Memory model with write log

  assign mcuReadData = mem[mcuAddr];  // Asynchronous read

  always @(negedge iClock)
  begin
    if (mcuWe)
    begin
      mem[mcuAddr] = mcuWriteData;
      logAddr.push_back(mcuAddr);
      logData.push_back(mcuWriteData);
    end
  end

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected)
    else
    begin
      $display("[ERROR] %s expected %h, got %h", name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic failCheck(input string what);
    $display("Check failed: %s", what);
    testErrors++;
  endtask

  // Random register among B, C, D, E and A so HL stays put
  function automatic logic [2:0] pickReg();
    logic [2:0] idx;
    idx = 3'($unsigned($random(seed)) % 5);
    return (idx == 3'd4) ? 3'd7 : idx;
  endfunction

  // --------------------------------------------------
  // Program building

  task automatic emit(input logic [7:0] b);
    mem[loadAddr] = b;
    loadAddr++;
  endtask

  task automatic emitOp(input logic [7:0] op);
    emit(op);
    instrCount++;
  endtask

  task automatic emitLdImm(input logic [2:0] r, input logic [7:0] n);
    emitOp({2'b00, r, 3'b110});
    emit(n);
  endtask

  task automatic emitStore(input logic [2:0] r, input logic [15:0] addr, input logic [7:0] data);
    emitOp({5'b01110, r});  // LD (HL),r
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // --------------------------------------------------
  // Test sequencing

  task automatic beginTest();
    @(negedge iClock);
    rstN = 1'b0;
    interruptRequests = 4'b0000;
    for (int i = 0; i < 65536; i++)
      mem[i] = 8'h00;
    logAddr.delete();
    logData.delete();
    expAddr.delete();
    expData.delete();
    loadAddr   = 16'h0100;
    instrCount = 0;
    testErrors = 0;
  endtask

  task automatic releaseReset();
    repeat (4)
    begin
      @(posedge iClock);
      assert (!mcuWe && !mcuReadRequest)
      else failCheck("write strobe or read request active during reset");
    end
    @(negedge iClock);
    rstN = 1'b1;
    checkValue("mcuAddr", 16'h0100, mcuAddr);  // First fetch
  endtask

  task automatic waitForAddr(input logic [15:0] addr);
    int cycles;
    cycles = 0;
    while (mcuAddr !== addr && cycles < 200 * instrCount)
    begin
      @(negedge iClock);
      cycles++;
    end
    if (mcuAddr !== addr)
      failCheck("program never reached the interrupt trigger point");
  endtask

  task automatic pulseIrq(input logic [3:0] lines);
    @(negedge iClock);
    interruptRequests = lines;
    @(negedge iClock);
    interruptRequests = 4'b0000;
  endtask

  task automatic endTest(input string name);
    int cycles;
    cycles = 0;
    while (logAddr.size() < expAddr.size() && cycles < 200 * instrCount)
    begin
      @(negedge iClock);
      cycles++;
    end
    if (logAddr.size() < expAddr.size())
      failCheck("timed out waiting for the expected memory writes");
    for (int i = 0; i < expAddr.size() && i < logAddr.size(); i++)
    begin
      checkValue("mcuAddr", expAddr[i], logAddr[i]);
      checkValue("mcuWriteData", {8'h00, expData[i]}, {8'h00, logData[i]});
    end
    testCount++;
    if (testErrors != 0)
      failedTests++;
    errorCount += testErrors;
    $display("%s: %0d writes expected, %0d errors", name, expAddr.size(), testErrors);
  endtask

  initial
  begin
    logic [7:0]  n;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  h;
    logic [7:0]  l;
    logic [2:0]  r;
    logic [2:0]  s;
    logic [15:0] trigger;
    rstN              = 1'b0;
    interruptRequests = 4'b0000;
    errorCount        = 0;
    testCount         = 0;
    failedTests       = 0;

    beginTest();
    n = 8'($random(seed));
    emitLdImm(3'd4, 8'hC0);
    emitLdImm(3'd5, 8'h10);
    emitLdImm(3'd7, n);
    emitStore(3'd7, 16'hC010, n);
    releaseReset();
    endTest("reset");

    // Every register through LD r,n and a store
    beginTest();
    for (int i = 0; i < 7; i++)
    begin
      r = regCodes[i];
      h = {5'b11000, 3'(i)};
      l = 8'($random(seed));
      n = 8'($random(seed));
      if (r == 3'd4)
        n = n | 8'hC0;  // Stores stay above the program
      emitLdImm(3'd4, h);
      emitLdImm(3'd5, l);
      emitLdImm(r, n);
      if (r == 3'd4)
        h = n;
      if (r == 3'd5)
        l = n;
      emitStore(r, {h, l}, n);
    end
    releaseReset();
    endTest("ld r,n");

    beginTest();
    emitLdImm(3'd4, 8'hD0);
    emitLdImm(3'd5, 8'h00);
    for (int i = 0; i < 4; i++)
    begin
      s = pickReg();
      r = pickReg();
      n = 8'($random(seed));
      emitLdImm(s, n);
      emitOp({2'b01, r, s});  // LD r,r'
      emitStore(r, 16'hD000, n);
    end
    releaseReset();
    endTest("ld r,r'");

    beginTest();
    emitLdImm(3'd4, 8'hE0);
    emitLdImm(3'd5, 8'h00);
    for (int i = 0; i < 3; i++)
    begin
      r = pickReg();
      if (r == 3'd7)
        r = 3'd0;
      a = 8'($random(seed));
      b = 8'($random(seed));
      emitLdImm(3'd7, a);
      emitLdImm(r, b);
      emitOp(aluOps[i] | {5'b00000, r});
      n = (i == 0) ? (a & b) : (i == 1) ? (a ^ b) : (a | b);
      emitStore(3'd7, 16'hE000, n);
    end
    releaseReset();
    endTest("alu");

    // Lines 1 and 2 together, line 1 wins with 0x48
    beginTest();
    emitLdImm(3'd4, 8'hF0);
    emitLdImm(3'd5, 8'h48);
    emitOp(8'hFB);  // EI
    trigger = loadAddr;
    repeat (8)
      emitOp(8'h00);
    emitLdImm(3'd7, 8'h11);
    emitOp(8'h77);
    n = 8'($random(seed)) | 8'h80;
    loadAddr = 16'h0048;
    emitLdImm(3'd7, n);
    emitStore(3'd7, 16'hF048, n);
    releaseReset();
    waitForAddr(trigger);
    pulseIrq(4'b0110);
    endTest("interrupt");

    beginTest();
    emitLdImm(3'd4, 8'hF1);
    emitLdImm(3'd5, 8'h00);
    emitOp(8'hFB);  // EI
    emitOp(8'hF3);  // DI
    trigger = loadAddr;
    repeat (6)
      emitOp(8'h00);
    a = 8'($random(seed));
    b = 8'($random(seed));
    emitLdImm(3'd7, a);
    emitStore(3'd7, 16'hF100, a);
    emitLdImm(3'd7, b);
    emitStore(3'd7, 16'hF100, b);
    loadAddr = 16'h0040;
    emitLdImm(3'd7, 8'hEE);  // Marker if line 0 were taken
    emitOp(8'h77);
    releaseReset();
    waitForAddr(trigger);
    pulseIrq(4'b0001);
    endTest("interrupts disabled");

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
             testCount, failedTests, errorCount, dut0.assert0.failCount);
    if (errorCount == 0 && dut0.assert0.failCount == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- verif/dzCpu_assert.sv
`timescale 1ns/1ps

module dzCpu_assert (
  input logic        iClock,
  input logic        rstN,
  input logic        mcuWe,
  input logic        mcuReadRequest,
  input logic [15:0] mcuAddr,
  input logic [15:0] hl
);

  int unsigned failCount = 0;

  // --------------------------------------------------
  // Memory port rules

  weWithReadReq: assert property (@(posedge iClock) !(mcuWe && mcuReadRequest))
  else
  begin
    $error("mcuWe and mcuReadRequest high in the same cycle");
    failCount++;
  end

  weInReset: assert property (@(posedge iClock) !rstN |-> !mcuWe)
  else
  begin
    $error("mcuWe high during reset");
    failCount++;
  end

  // One-cycle strobe
  weSingleCycle: assert property (@(posedge iClock) disable iff (!rstN) mcuWe |=> !mcuWe)
  else
  begin
    $error("mcuWe held for two cycles");
    failCount++;
  end

  weAtHl: assert property (@(posedge iClock) disable iff (!rstN) mcuWe |-> mcuAddr == hl)
  else
  begin
    $error("write address differs from HL");
    failCount++;
  end

  // Store flow ends with the address back on pc
  readReqAfterWe: assert property (@(posedge iClock) disable iff (!rstN)
                                   mcuWe |-> ##2 mcuReadRequest)
  else
  begin
    $error("no read request after a memory write");
    failCount++;
  end

endmodule

bind dzCpu dzCpu_assert assert0 (
  .iClock         (iClock),
  .rstN           (rstN),
  .mcuWe          (mcuWe),
  .mcuReadRequest (mcuReadRequest),
  .mcuAddr        (mcuAddr),
  .hl             (hl)
);

//--- verilog/cpuPkg.sv
package cpuPkg;

  // --------------------------------------------------
  // Micro-op format

  typedef enum logic [4:0] {
    nop     = 5'd0,
    sma     = 5'd1,  // Set memory address source
    srm     = 5'd2,  // Store read memory into register
    smw     = 5'd3,  // Memory write strobe
    z801bop = 5'd4,  // One-operand Z80 op
    seti    = 5'd5,
    ceti    = 5'd6,
    jint    = 5'd7   // Jump to interrupt vector
  } uopCmdT;

  typedef struct packed {
    logic       incPc;
    logic       eof;
    uopCmdT     cmd;
    logic [4:0] operand;
  } uopT;

  // Operand codes
  localparam logic [4:0] opNone = 5'd0;
  localparam logic [4:0] addrPc = 5'd1;
  localparam logic [4:0] addrHl = 5'd2;
  localparam logic [4:0] opDst  = 5'd3;  // Register from opcode bits 5:3
  localparam logic [4:0] opSrc  = 5'd4;  // Register from opcode bits 2:0

  // --------------------------------------------------
  // Sequencer

  typedef enum logic [1:0] {
    afterReset = 2'd0,
    startFlow  = 2'd1,
    runFlow    = 2'd2,
    endFlow    = 2'd3
  } seqStateT;

  localparam int uPcWidth = 6;

  // Flow start addresses in the micro-op store
  localparam logic [uPcWidth-1:0] flowNop     = 6'd0;
  localparam logic [uPcWidth-1:0] flowOneOp   = 6'd1;
  localparam logic [uPcWidth-1:0] flowLdImm   = 6'd2;  // Two micro-ops
  localparam logic [uPcWidth-1:0] flowStoreHl = 6'd4;  // Three micro-ops
  localparam logic [uPcWidth-1:0] flowEi      = 6'd7;
  localparam logic [uPcWidth-1:0] flowDi      = 6'd8;
  localparam logic [uPcWidth-1:0] flowInt     = 6'd9;

endpackage

//--- verilog/dzCpu.sv
`timescale 1ns/1ps

module dzCpu #(
  parameter z80Pkg::addrT ResetPc = 16'h0100
) (
  input  logic         iClock,
  input  logic         rstN,
  input  z80Pkg::dataT mcuReadData,
  input  logic [3:0]   interruptRequests,
  output z80Pkg::addrT mcuAddr,
  output z80Pkg::dataT mcuWriteData,
  output logic         mcuWe,
  output logic         mcuReadRequest
);

  logic           flowEnable;
  cpuPkg::uopT    uop;
  z80Pkg::dataT   opcode;
  z80Pkg::regIdxT regReadSel;
  z80Pkg::regIdxT regWriteSel;
  logic           regWriteEn;
  z80Pkg::dataT   regWriteData;
  z80Pkg::dataT   regReadData;
  z80Pkg::dataT   regA;
  z80Pkg::addrT   hl;
  z80Pkg::addrT   pc;
  logic           pcInc;
  logic           pcLoad;
  z80Pkg::addrT   pcLoadValue;
  logic           setIntEnable;
  logic           intEnableValue;
  logic           clearPending;
  logic           intTaken;
  z80Pkg::addrT   vector;

  microSequencer seq0 (
    .iClock      (iClock),
    .rstN        (rstN),
    .mcuReadData (mcuReadData),
    .intTaken    (intTaken),
    .flowEnable  (flowEnable),
    .uop         (uop),
    .opcode      (opcode)
  );

  uopExecute exec0 (
    .iClock (iClock), .rstN (rstN), .flowEnable (flowEnable), .uop (uop),
    .opcode (opcode), .mcuReadData (mcuReadData), .regReadData (regReadData),
    .regA (regA), .hl (hl), .pc (pc), .vector (vector),
    .regReadSel (regReadSel), .regWriteEn (regWriteEn), .regWriteSel (regWriteSel),
    .regWriteData (regWriteData), .pcInc (pcInc), .pcLoad (pcLoad),
    .pcLoadValue (pcLoadValue), .mcuAddr (mcuAddr), .mcuWriteData (mcuWriteData),
    .mcuWe (mcuWe), .mcuReadRequest (mcuReadRequest), .setIntEnable (setIntEnable),
    .intEnableValue (intEnableValue), .clearPending (clearPending)
  );

  registerFile #(.ResetPc (ResetPc)) regs0 (
    .iClock (iClock), .rstN (rstN), .regWriteEn (regWriteEn),
    .regWriteSel (regWriteSel), .regWriteData (regWriteData), .regReadSel (regReadSel),
    .pcInc (pcInc), .pcLoad (pcLoad), .pcLoadValue (pcLoadValue),
    .regReadData (regReadData), .regA (regA), .hl (hl), .pc (pc)
  );

  interruptCtrl int0 (
    .iClock (iClock), .rstN (rstN), .interruptRequests (interruptRequests),
    .setIntEnable (setIntEnable), .intEnableValue (intEnableValue),
    .clearPending (clearPending), .intTaken (intTaken), .vector (vector)
  );

endmodule

//--- verilog/interruptCtrl.sv
`timescale 1ns/1ps

module interruptCtrl (
  input  logic         iClock,
  input  logic         rstN,
  input  logic [3:0]   interruptRequests,
  input  logic         setIntEnable,
  input  logic         intEnableValue,
  input  logic         clearPending,
  output logic         intTaken,
  output z80Pkg::addrT vector
);

  logic       intEnable;
  logic [3:0] pending;

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      intEnable <= 1'b0;
      pending   <= '0;
    end
    else
    begin
      if (setIntEnable)
        intEnable <= intEnableValue;
      if (clearPending)
        pending <= '0;
      else
        pending <= pending | interruptRequests;  // Sticky until jint
    end
  end

  assign intTaken = intEnable & (|pending);

  // Lowest line number wins
  always_comb
  begin
    if (pending[0])      vector = z80Pkg::intVector0;
    else if (pending[1]) vector = z80Pkg::intVector1;
    else if (pending[2]) vector = z80Pkg::intVector2;
    else if (pending[3]) vector = z80Pkg::intVector3;
    else                 vector = '0;
  end

endmodule

//--- verilog/microSequencer.sv
`timescale 1ns/1ps

module microSequencer (
  input  logic         iClock,
  input  logic         rstN,
  input  z80Pkg::dataT mcuReadData,
  input  logic         intTaken,
  output logic         flowEnable,
  output cpuPkg::uopT  uop,
  output z80Pkg::dataT opcode
);

  cpuPkg::seqStateT                state;
  cpuPkg::seqStateT                nextState;
  logic [cpuPkg::uPcWidth-1:0]     uPc;
  logic [cpuPkg::uPcWidth-1:0]     flowStart;

  microcodeRom rom0 (
    .uAddr     (uPc),
    .opcode    (mcuReadData),  // Fetched byte, address is pc in startFlow
    .flowStart (flowStart),
    .uop       (uop)
  );

  // --------------------------------------------------
  // Flow state machine

  always_comb
  begin
    case (state)
      cpuPkg::afterReset: nextState = cpuPkg::startFlow;
      cpuPkg::startFlow:  nextState = cpuPkg::runFlow;
      cpuPkg::runFlow:    nextState = uop.eof ? cpuPkg::endFlow : cpuPkg::runFlow;
      default:            nextState = cpuPkg::startFlow;
    endcase
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      state <= cpuPkg::afterReset;
    else
      state <= nextState;
  end

  assign flowEnable = (state == cpuPkg::runFlow);

  // Micro program counter
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      uPc <= cpuPkg::flowNop;
    else if (state == cpuPkg::startFlow)
      uPc <= intTaken ? cpuPkg::flowInt : flowStart;
    else if (state == cpuPkg::runFlow)
      uPc <= uPc + 1'b1;
  end

  // Opcode held for the whole flow
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      opcode <= '0;
    else if (state == cpuPkg::startFlow)
      opcode <= mcuReadData;
  end

endmodule

//--- verilog/microcodeRom.sv
`timescale 1ns/1ps

module microcodeRom (
  input  logic [cpuPkg::uPcWidth-1:0] uAddr,
  input  z80Pkg::dataT                opcode,
  output logic [cpuPkg::uPcWidth-1:0] flowStart,
  output cpuPkg::uopT                 uop
);

  function automatic cpuPkg::uopT mkUop(
    input logic           inc,
    input logic           last,
    input cpuPkg::uopCmdT command,
    input logic [4:0]     opnd
  );
    return '{incPc: inc, eof: last, cmd: command, operand: opnd};
  endfunction

  // --------------------------------------------------
  // Micro-op store

  always_comb
  begin
    case (uAddr)
      cpuPkg::flowNop:
        uop = mkUop(1'b1, 1'b1, cpuPkg::nop, cpuPkg::opNone);
      cpuPkg::flowOneOp:
        uop = mkUop(1'b1, 1'b1, cpuPkg::z801bop, cpuPkg::opSrc);
      cpuPkg::flowLdImm:
        uop = mkUop(1'b1, 1'b0, cpuPkg::nop, cpuPkg::opNone);    // Step onto n
      cpuPkg::flowLdImm + 6'd1:
        uop = mkUop(1'b1, 1'b1, cpuPkg::srm, cpuPkg::opDst);
      cpuPkg::flowStoreHl:
        uop = mkUop(1'b0, 1'b0, cpuPkg::sma, cpuPkg::addrHl);
      cpuPkg::flowStoreHl + 6'd1:
        uop = mkUop(1'b0, 1'b0, cpuPkg::smw, cpuPkg::opSrc);
      cpuPkg::flowStoreHl + 6'd2:
        uop = mkUop(1'b1, 1'b1, cpuPkg::sma, cpuPkg::addrPc);  // Back to fetch
      cpuPkg::flowEi:
        uop = mkUop(1'b1, 1'b1, cpuPkg::seti, cpuPkg::opNone);
      cpuPkg::flowDi:
        uop = mkUop(1'b1, 1'b1, cpuPkg::ceti, cpuPkg::opNone);
      cpuPkg::flowInt:
        uop = mkUop(1'b0, 1'b1, cpuPkg::jint, cpuPkg::opNone);
      default:
        uop = mkUop(1'b0, 1'b1, cpuPkg::nop, cpuPkg::opNone);
    endcase
  end

  // --------------------------------------------------
  // Opcode to flow lookup

  always_comb
  begin
    flowStart = cpuPkg::flowNop;
    if (opcode == z80Pkg::opNop)
      flowStart = cpuPkg::flowNop;
    else if ((opcode & z80Pkg::opStoreHlMask) == z80Pkg::opStoreHl &&
             opcode[2:0] != z80Pkg::idxMem)
      flowStart = cpuPkg::flowStoreHl;  // Must win over LD r,r'
    else if ((opcode & z80Pkg::opLdRrMask) == z80Pkg::opLdRr &&
             opcode[5:3] != z80Pkg::idxMem && opcode[2:0] != z80Pkg::idxMem)
      flowStart = cpuPkg::flowOneOp;
    else if ((opcode & z80Pkg::opAluMask) inside {z80Pkg::opAnd, z80Pkg::opXor, z80Pkg::opOr} &&
             opcode[2:0] != z80Pkg::idxMem)
      flowStart = cpuPkg::flowOneOp;
    else if ((opcode & z80Pkg::opLdImmMask) == z80Pkg::opLdImm &&
             opcode[5:3] != z80Pkg::idxMem)
      flowStart = cpuPkg::flowLdImm;
    else if (opcode == z80Pkg::opEi)
      flowStart = cpuPkg::flowEi;
    else if (opcode == z80Pkg::opDi)
      flowStart = cpuPkg::flowDi;
  end

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
  parameter z80Pkg::addrT ResetPc = 16'h0100
) (
  input  logic           iClock,
  input  logic           rstN,
  input  logic           regWriteEn,
  input  z80Pkg::regIdxT regWriteSel,
  input  z80Pkg::dataT   regWriteData,
  input  z80Pkg::regIdxT regReadSel,
  input  logic           pcInc,
  input  logic           pcLoad,
  input  z80Pkg::addrT   pcLoadValue,
  output z80Pkg::dataT   regReadData,
  output z80Pkg::dataT   regA,
  output z80Pkg::addrT   hl,
  output z80Pkg::addrT   pc
);

  // Indexed as in the opcode, slot 6 stays idle
  z80Pkg::dataT regs [8];

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      regs <= '{default: '0};
    else if (regWriteEn)
      regs[regWriteSel] <= regWriteData;
  end

  // --------------------------------------------------
  // Program counter

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      pc <= ResetPc;
    else if (pcLoad)
      pc <= pcLoadValue;  // Jump wins over increment
    else if (pcInc)
      pc <= pc + 16'd1;
  end

  assign regReadData = regs[regReadSel];
  assign regA        = regs[z80Pkg::idxA];
  assign hl          = {regs[z80Pkg::idxH], regs[z80Pkg::idxL]};

endmodule

//--- verilog/uopExecute.sv
`timescale 1ns/1ps

module uopExecute (
  input  logic           iClock,
  input  logic           rstN,
  input  logic           flowEnable,
  input  cpuPkg::uopT    uop,
  input  z80Pkg::dataT   opcode,
  input  z80Pkg::dataT   mcuReadData,
  input  z80Pkg::dataT   regReadData,
  input  z80Pkg::dataT   regA,
  input  z80Pkg::addrT   hl,
  input  z80Pkg::addrT   pc,
  input  z80Pkg::addrT   vector,
  output z80Pkg::regIdxT regReadSel,
  output logic           regWriteEn,
  output z80Pkg::regIdxT regWriteSel,
  output z80Pkg::dataT   regWriteData,
  output logic           pcInc,
  output logic           pcLoad,
  output z80Pkg::addrT   pcLoadValue,
  output z80Pkg::addrT   mcuAddr,
  output z80Pkg::dataT   mcuWriteData,
  output logic           mcuWe,
  output logic           mcuReadRequest,
  output logic           setIntEnable,
  output logic           intEnableValue,
  output logic           clearPending
);

  z80Pkg::regIdxT operandReg;
  z80Pkg::dataT   aluResult;
  logic           isLdRr;
  logic           addrSelHl;
  logic           readReqQ;

  // Register named by the micro-op operand
  assign operandReg = (uop.operand == cpuPkg::opDst) ? z80Pkg::regIdxT'(opcode[5:3])
                                                     : z80Pkg::regIdxT'(opcode[2:0]);
  assign isLdRr     = (opcode & z80Pkg::opLdRrMask) == z80Pkg::opLdRr;

  // --------------------------------------------------
  // Operand ALU

  always_comb
  begin
    case (opcode & z80Pkg::opAluMask)
      z80Pkg::opAnd: aluResult = regA & regReadData;
      z80Pkg::opXor: aluResult = regA ^ regReadData;
      z80Pkg::opOr:  aluResult = regA | regReadData;
      default:       aluResult = regReadData;  // LD r,r'
    endcase
  end

  // --------------------------------------------------
  // Command decode

  always_comb
  begin
    regWriteEn     = 1'b0;
    regWriteSel    = operandReg;
    regWriteData   = mcuReadData;
    pcLoad         = 1'b0;
    mcuWe          = 1'b0;
    setIntEnable   = 1'b0;
    intEnableValue = 1'b0;
    clearPending   = 1'b0;
    if (flowEnable)
    begin
      case (uop.cmd)
        cpuPkg::srm:
          regWriteEn = 1'b1;
        cpuPkg::smw:
          mcuWe = 1'b1;
        cpuPkg::z801bop:
        begin
          regWriteEn   = 1'b1;
          regWriteSel  = isLdRr ? z80Pkg::regIdxT'(opcode[5:3]) : z80Pkg::idxA;
          regWriteData = aluResult;
        end
        cpuPkg::seti:
        begin
          setIntEnable   = 1'b1;
          intEnableValue = 1'b1;
        end
        cpuPkg::ceti:
          setIntEnable = 1'b1;
        cpuPkg::jint:
        begin
          pcLoad       = 1'b1;
          clearPending = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign regReadSel   = operandReg;
  assign pcInc        = flowEnable & uop.incPc;
  assign pcLoadValue  = vector;
  assign mcuWriteData = regReadData;
  assign mcuAddr      = addrSelHl ? hl : pc;

  // Address source and read request
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      addrSelHl <= 1'b0;
      readReqQ  <= 1'b0;
    end
    else
    begin
      readReqQ <= 1'b0;
      if (flowEnable && uop.cmd == cpuPkg::sma)
      begin
        addrSelHl <= (uop.operand == cpuPkg::addrHl);
        readReqQ  <= (uop.operand == cpuPkg::addrPc);  // HL is only used to store
      end
    end
  end

  assign mcuReadRequest = readReqQ;

endmodule

//--- verilog/z80Pkg.sv
package z80Pkg;

  typedef logic [7:0]  dataT;
  typedef logic [15:0] addrT;

  // Register index in opcode order
  typedef enum logic [2:0] {
    idxB = 3'd0,
    idxC = 3'd1,
    idxD = 3'd2,
    idxE = 3'd3,
    idxH = 3'd4,
    idxL = 3'd5,
    idxA = 3'd7
  } regIdxT;

  localparam logic [2:0] idxMem = 3'd6;  // (HL) operand, not a register

  // Interrupt vectors by line
  localparam addrT intVector0 = 16'h0040;
  localparam addrT intVector1 = 16'h0048;
  localparam addrT intVector2 = 16'h0050;
  localparam addrT intVector3 = 16'h0060;

  // --------------------------------------------------
  // Opcodes and group masks

  localparam dataT opNop         = 8'h00;
  localparam dataT opEi          = 8'hFB;
  localparam dataT opDi          = 8'hF3;
  localparam dataT opLdRr        = 8'h40;  // 01 ddd sss
  localparam dataT opLdRrMask    = 8'hC0;
  localparam dataT opAnd         = 8'hA0;  // 10100 sss
  localparam dataT opXor         = 8'hA8;
  localparam dataT opOr          = 8'hB0;
  localparam dataT opAluMask     = 8'hF8;
  localparam dataT opLdImm       = 8'h06;  // 00 ddd 110
  localparam dataT opLdImmMask   = 8'hC7;
  localparam dataT opStoreHl     = 8'h70;  // 01110 sss
  localparam dataT opStoreHlMask = 8'hF8;

endpackage
